// File: filelist.f
+incdir+tb
source/sub_board_pkg.sv
source/sub_maps_pkg.sv
source/board_if.sv
source/board_store.sv
source/ship_tracer.sv
source/shot_control.sv
source/game_regs.sv
source/submarine_top.sv
tb/tb_submarine.sv

// File: tb/shot_table.svh
/*
  Stimulus rows for the submarine testbench, applied in order.
  Shot rows assume the map of the last load row before them.
  A busy offer aims a second shot at OFFER_X,OFFER_Y while the first is in flight.
*/
`ifndef SHOT_TABLE_SVH
`define SHOT_TABLE_SVH

typedef enum logic [2:0] {OUT_MISS, OUT_HIT, OUT_SINK, OUT_DONE, OUT_IGNORED} outcome_t;

typedef enum logic {OP_LOAD, OP_SHOT} op_t;

typedef struct packed {
    op_t                    op;
    sub_maps_pkg::map_sel_t map;          // loads only
    sub_board_pkg::coord_t  x;
    sub_board_pkg::coord_t  y;
    logic                   busy_offer;   // offer a second shot while busy
    outcome_t               want;
} shot_row_t;

// single-cell submarine of map 0 that is still live when the offer is made
localparam sub_board_pkg::coord_t OFFER_X = 3'd2;
localparam sub_board_pkg::coord_t OFFER_Y = 3'd0;

localparam int NUM_ROWS = 46;

localparam shot_row_t SHOT_ROWS [NUM_ROWS] = '{
    '{OP_LOAD, 2'd0, 3'd0, 3'd0, 1'b0, OUT_MISS},
    '{OP_SHOT, 2'd0, 3'd0, 3'd0, 1'b0, OUT_HIT},       // length 3 at x0
    '{OP_SHOT, 2'd0, 3'd0, 3'd1, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd0, 3'd2, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd0, 3'd1, 1'b0, OUT_MISS},      // wreck again
    '{OP_SHOT, 2'd0, 3'd6, 3'd2, 1'b0, OUT_IGNORED},
    '{OP_SHOT, 2'd0, 3'd3, 3'd7, 1'b0, OUT_IGNORED},
    '{OP_SHOT, 2'd0, 3'd1, 3'd4, 1'b1, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd2, 3'd4, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd2, 3'd0, 1'b0, OUT_SINK},      // offer above was dropped
    '{OP_SHOT, 2'd0, 3'd4, 3'd1, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd2, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd3, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd4, 1'b0, OUT_DONE},
    '{OP_SHOT, 2'd0, 3'd4, 3'd4, 1'b0, OUT_MISS},
    '{OP_SHOT, 2'd0, 3'd3, 3'd3, 1'b0, OUT_MISS},
    '{OP_LOAD, 2'd0, 3'd0, 3'd0, 1'b0, OUT_MISS},      // reload clears done
    '{OP_SHOT, 2'd0, 3'd0, 3'd0, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd4, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd3, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd2, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd1, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd0, 3'd2, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd0, 3'd1, 1'b0, OUT_SINK},      // middle cell last
    '{OP_SHOT, 2'd0, 3'd2, 3'd0, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd2, 3'd4, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd1, 3'd4, 1'b0, OUT_DONE},
    '{OP_LOAD, 2'd3, 3'd0, 3'd0, 1'b0, OUT_MISS},
    '{OP_SHOT, 2'd0, 3'd0, 3'd0, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd2, 3'd0, 1'b0, OUT_HIT},
    '{OP_LOAD, 2'd3, 3'd0, 3'd0, 1'b0, OUT_MISS},      // mid-game reload
    '{OP_SHOT, 2'd0, 3'd2, 3'd0, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd2, 3'd1, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd0, 3'd0, 1'b0, OUT_SINK},      // struck again after the reload
    '{OP_SHOT, 2'd0, 3'd0, 3'd2, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd0, 3'd4, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd2, 3'd3, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd2, 3'd5, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd4, 3'd0, 1'b0, OUT_SINK},
    '{OP_SHOT, 2'd0, 3'd4, 3'd2, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd3, 1'b0, OUT_HIT},
    '{OP_SHOT, 2'd0, 3'd4, 3'd4, 1'b0, OUT_DONE},      // count restarted at the reload
    '{OP_LOAD, 2'd1, 3'd0, 3'd0, 1'b0, OUT_MISS},
    '{OP_SHOT, 2'd0, 3'd0, 3'd1, 1'b0, OUT_SINK},      // single cell of map 1
    '{OP_LOAD, 2'd2, 3'd0, 3'd0, 1'b0, OUT_MISS},
    '{OP_SHOT, 2'd0, 3'd3, 3'd2, 1'b0, OUT_SINK}       // single cell of map 2
};

`endif

// File: tb/tb_submarine.sv
/*
  Testbench for submarine_top, driven row by row from the shot table.
  Water cells and live counts come from the map package.
  A wait on busy gives up after 64 cycles and stops the table.
*/
`timescale 1ns/1ps

module tb_submarine;

    `include "shot_table.svh"

    localparam int WAIT_LIMIT = 64;

    logic                      clk;
    logic                      rstn;
    sub_maps_pkg::map_sel_t    init_select;
    logic                      select_valid;
    sub_board_pkg::coord_t     x;
    sub_board_pkg::coord_t     y;
    logic                      cord_valid;
    logic                      busy;
    logic                      hit;
    logic                      sink;
    logic                      done;

    int                        errors;
    int                        checks;
    logic                      timed_out;
    logic                      exp_done;     // done level implied by the rows so far
    logic [31:0]               rng;
    sub_maps_pkg::map_sel_t    cur_map;
    sub_maps_pkg::live_count_t struck;       // ship cells struck since the last load

    submarine_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    task automatic check_outcome(string name, outcome_t want, outcome_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: expected %s, actual %s", name, want.name(), got.name());
        end
    endtask

    task automatic check_level(string name, logic want, logic got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, want, got);
        end
    endtask

    task automatic check_count(string name, sub_maps_pkg::live_count_t want,
                               sub_maps_pkg::live_count_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, want, got);
        end
    endtask

    task automatic report_problem(string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic load_map(sub_maps_pkg::map_sel_t m);
        @(posedge clk);
        init_select  <= m;
        select_valid <= 1'b1;
        @(posedge clk);
        select_valid <= 1'b0;
        @(negedge clk);
        check_level("after load busy", 1'b0, busy);
        check_level("after load hit", 1'b0, hit);
        check_level("after load sink", 1'b0, sink);
        check_level("after load done", 1'b0, done);
    endtask

    task automatic fire_shot(sub_board_pkg::coord_t sx, sub_board_pkg::coord_t sy,
                             logic offer, output outcome_t got);
        int   waited;
        logic done_rise;
        logic done_before;
        @(posedge clk);
        x          <= sx;
        y          <= sy;
        cord_valid <= 1'b1;
        @(posedge clk);                    // shot taken at this edge
        if (offer) begin
            x <= OFFER_X;                  // held one more cycle while busy
            y <= OFFER_Y;
        end else begin
            cord_valid <= 1'b0;
        end
        @(negedge clk);
        done_before = done;
        waited      = 0;
        while (busy && waited < WAIT_LIMIT) begin
            @(posedge clk);
            cord_valid <= 1'b0;
            @(negedge clk);
            waited++;
        end
        done_rise = done && !done_before;
        got       = OUT_MISS;
        if (busy) begin
            timed_out = 1'b1;
            report_problem($sformatf("busy stayed high for %0d cycles after the shot at %0d,%0d",
                                     WAIT_LIMIT, sx, sy));
        end else if (hit) begin
            got = OUT_HIT;
        end else if (sink) begin
            got = OUT_SINK;
        end else if (done_rise) begin
            got = OUT_DONE;
        end else if (waited == 0) begin
            got = OUT_IGNORED;
        end
        if (int'(hit) + int'(sink) + int'(done_rise) > 1) begin
            report_problem($sformatf("more than one result at once for the shot at %0d,%0d",
                                     sx, sy));
        end
        if (got == OUT_MISS && waited != 1 && !timed_out) begin
            report_problem($sformatf("miss at %0d,%0d kept busy high for %0d cycles, not 1",
                                     sx, sy, waited));
        end
    endtask

    // every water cell of a fresh map must miss
    task automatic sweep_water(sub_maps_pkg::map_sel_t m);
        outcome_t got;
        int       idx;
        for (int i = 0; i < sub_board_pkg::BOARD_DIM; i++) begin
            for (int j = 0; j < sub_board_pkg::BOARD_DIM; j++) begin
                idx = i * sub_board_pkg::BOARD_DIM + j;
                if (!timed_out &&
                    sub_maps_pkg::MAP_TABLE[m][idx] == sub_board_pkg::CELL_WATER) begin
                    fire_shot(sub_board_pkg::coord_t'(i), sub_board_pkg::coord_t'(j), 1'b0, got);
                    check_outcome($sformatf("map %0d water %0d,%0d", m, i, j), OUT_MISS, got);
                end
            end
        end
    endtask

    initial begin
        string     name;
        outcome_t  got;
        shot_row_t row;
        int        errors_before;
        int        rows_run;
        rstn         = 1'b0;
        init_select  = '0;
        select_valid = 1'b0;
        x            = '0;
        y            = '0;
        cord_valid   = 1'b0;
        errors       = 0;
        checks       = 0;
        rows_run     = 0;
        timed_out    = 1'b0;
        exp_done     = 1'b0;
        rng          = 32'd24953;
        cur_map      = '0;
        struck       = '0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_level("reset busy", 1'b0, busy);
        check_level("reset hit", 1'b0, hit);
        check_level("reset sink", 1'b0, sink);
        check_level("reset done", 1'b0, done);
        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            row           = SHOT_ROWS[i];
            errors_before = errors;
            rng           = xorshift(rng);
            repeat (rng[1:0]) @(posedge clk);      // idle gap of 0 to 3 cycles
            if (row.op == OP_LOAD) begin
                name     = $sformatf("row %0d load map %0d", i, row.map);
                cur_map  = row.map;
                struck   = '0;
                exp_done = 1'b0;
                load_map(row.map);
                sweep_water(row.map);
            end else begin
                name = $sformatf("row %0d shot %0d,%0d%s", i, row.x, row.y,
                                 row.busy_offer ? " with busy offer" : "");
                fire_shot(row.x, row.y, row.busy_offer, got);
                check_outcome(name, row.want, got);
                if (got == OUT_HIT || got == OUT_SINK || got == OUT_DONE) begin
                    struck++;
                end
                if (row.want == OUT_DONE) begin
                    exp_done = 1'b1;
                    check_count({name, " live count"}, sub_maps_pkg::MAP_LIVE[cur_map], struck);
                end
            end
            check_level({name, " done level"}, exp_done, done);
            rows_run++;
            $display("%s: %s", name, (errors == errors_before) ? "ok" : "mismatch");
        end
        $display("rows %0d of %0d, checks %0d, errors %0d", rows_run, NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: source/submarine_top.sv
/*
  Submarine game top level.
  Shots are taken only while busy is low; a shot offered while busy is lost.
  hit and sink are one-cycle pulses; done is a level cleared by a load.
*/
`timescale 1ns/1ps

module submarine_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  sub_maps_pkg::map_sel_t  init_select,
    input  logic                    select_valid,
    input  sub_board_pkg::coord_t   x,
    input  sub_board_pkg::coord_t   y,
    input  logic                    cord_valid,
    output logic                    busy,
    output logic                    hit,
    output logic                    sink,
    output logic                    done
);

    board_if bus_if ();

    logic                  trace_start;
    logic                  trace_done;
    logic                  alive;
    logic                  cell_struck;
    logic                  ship_sunk;
    sub_board_pkg::coord_t origin_x;
    sub_board_pkg::coord_t origin_y;

    board_store u_store (
        .clk          (clk),
        .rstn         (rstn),
        .init_select  (init_select),
        .select_valid (select_valid),
        .bus          (bus_if.store)
    );

    ship_tracer u_tracer (
        .clk         (clk),
        .rstn        (rstn),
        .bus         (bus_if.reader),
        .trace_start (trace_start),
        .origin_x    (origin_x),
        .origin_y    (origin_y),
        .trace_done  (trace_done),
        .alive       (alive)
    );

    shot_control u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .select_valid (select_valid),
        .x            (x),
        .y            (y),
        .cord_valid   (cord_valid),
        .bus          (bus_if.writer),
        .trace_start  (trace_start),
        .origin_x     (origin_x),
        .origin_y     (origin_y),
        .trace_done   (trace_done),
        .alive        (alive),
        .busy         (busy),
        .hit          (hit),
        .cell_struck  (cell_struck),
        .ship_sunk    (ship_sunk)
    );

    game_regs u_regs (
        .clk          (clk),
        .rstn         (rstn),
        .init_select  (init_select),
        .select_valid (select_valid),
        .cell_struck  (cell_struck),
        .ship_sunk    (ship_sunk),
        .sink         (sink),
        .done         (done)
    );

endmodule

// File: source/game_regs.sv
/*
  Live-cell counter with the sink and done outputs.
  The count loads from the map table on a load and drops on every strike.
  A sunk submarine with no live cells left raises done instead of sink;
  done holds until the next load or reset.
*/
`timescale 1ns/1ps

module game_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  sub_maps_pkg::map_sel_t  init_select,
    input  logic                    select_valid,
    input  logic                    cell_struck,
    input  logic                    ship_sunk,
    output logic                    sink,
    output logic                    done
);

    sub_maps_pkg::live_count_t live_cnt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            live_cnt <= '0;
            sink     <= 1'b0;
            done     <= 1'b0;
        end else if (select_valid) begin
            live_cnt <= sub_maps_pkg::MAP_LIVE[init_select];
            sink     <= 1'b0;
            done     <= 1'b0;
        end else begin
            if (cell_struck && live_cnt != '0) begin
                live_cnt <= live_cnt - 1'b1;
            end
            sink <= ship_sunk && live_cnt != '0;
            if (ship_sunk && live_cnt == '0) begin
                done <= 1'b1;              // last submarine gone
            end
        end
    end

endmodule

// File: source/shot_control.sv
/*
  Shot controller: takes one shot at a time and judges the struck cell.
  Shots while busy, or with a coordinate of 6 or 7, are dropped.
  A miss keeps busy high for one cycle; a strike waits for the tracer.
  hit shows in the first cycle with busy low again.
*/
`timescale 1ns/1ps

module shot_control (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   select_valid,
    input  sub_board_pkg::coord_t  x,
    input  sub_board_pkg::coord_t  y,
    input  logic                   cord_valid,
    board_if.writer                bus,
    output logic                   trace_start,
    output sub_board_pkg::coord_t  origin_x,
    output sub_board_pkg::coord_t  origin_y,
    input  logic                   trace_done,
    input  logic                   alive,
    output logic                   busy,
    output logic                   hit,
    output logic                   cell_struck,
    output logic                   ship_sunk
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_JUDGE,
        ST_TRACE,
        ST_REPORT
    } state_t;

    state_t                state;
    sub_board_pkg::coord_t shot_x;
    sub_board_pkg::coord_t shot_y;
    logic                  alive_q;
    logic                  accept;
    logic                  is_ship;
    logic                  strike;

    assign accept = cord_valid && !select_valid && state == ST_IDLE &&
                    x < sub_board_pkg::BOARD_DIM && y < sub_board_pkg::BOARD_DIM;

    assign is_ship = bus.cells[sub_board_pkg::cell_index(shot_x, shot_y)] ==
                     sub_board_pkg::CELL_SHIP;
    assign strike  = state == ST_JUDGE && is_ship && !select_valid;

    // the wreck write and the tracer seed share the judge cycle;
    // the tracer only reads the board from the next cycle on
    assign bus.wr_en   = strike;
    assign bus.wr_x    = shot_x;
    assign bus.wr_y    = shot_y;
    assign bus.wr_cell = sub_board_pkg::CELL_WRECK;
    assign trace_start = strike;
    assign cell_struck = strike;
    assign origin_x    = shot_x;
    assign origin_y    = shot_y;
    assign busy        = state != ST_IDLE;

    always_ff @(posedge clk) begin
        if (accept) begin
            shot_x <= x;
            shot_y <= y;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            hit       <= 1'b0;
            ship_sunk <= 1'b0;
            alive_q   <= 1'b0;
        end else if (select_valid) begin   // a load aborts any shot in flight
            state     <= ST_IDLE;
            hit       <= 1'b0;
            ship_sunk <= 1'b0;
            alive_q   <= 1'b0;
        end else begin
            hit       <= 1'b0;
            ship_sunk <= 1'b0;
            case (state)
                ST_IDLE:   if (accept) state <= ST_JUDGE;
                ST_JUDGE:  state <= is_ship ? ST_TRACE : ST_IDLE;   // water or wreck is a miss
                ST_TRACE: begin
                    if (trace_done) begin
                        alive_q   <= alive;
                        ship_sunk <= !alive;   // sink or done lands with the hit slot
                        state     <= ST_REPORT;
                    end
                end
                ST_REPORT: begin
                    hit   <= alive_q;
                    state <= ST_IDLE;
                end
                default:   state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/ship_tracer.sv
/*
  Decides whether the submarine under the origin cell still has a live cell.
  The reached mask grows by one ring of wreck cells per cycle.
  Submarines never touch, so the flood stays inside the struck submarine.
  trace_done comes 1 to 5 cycles after trace_start; a new start restarts it.
*/
`timescale 1ns/1ps

module ship_tracer (
    input  logic                   clk,
    input  logic                   rstn,
    board_if.reader                bus,
    input  logic                   trace_start,
    input  sub_board_pkg::coord_t  origin_x,
    input  sub_board_pkg::coord_t  origin_y,
    output logic                   trace_done,
    output logic                   alive
);

    logic                     running;
    sub_board_pkg::cell_mask_t reached;
    sub_board_pkg::cell_mask_t near;     // side or corner neighbor of a reached cell
    sub_board_pkg::cell_mask_t wreck;
    sub_board_pkg::cell_mask_t ship;
    sub_board_pkg::cell_mask_t grow;

    always_comb begin
        int nx;
        int ny;
        near = '0;
        for (int i = 0; i < sub_board_pkg::BOARD_DIM; i++) begin
            for (int j = 0; j < sub_board_pkg::BOARD_DIM; j++) begin
                for (int dx = -1; dx <= 1; dx++) begin
                    for (int dy = -1; dy <= 1; dy++) begin
                        nx = i + dx;
                        ny = j + dy;
                        if (nx >= 0 && nx < sub_board_pkg::BOARD_DIM &&
                            ny >= 0 && ny < sub_board_pkg::BOARD_DIM) begin
                            if (reached[nx*sub_board_pkg::BOARD_DIM+ny]) begin
                                near[i*sub_board_pkg::BOARD_DIM+j] = 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < sub_board_pkg::CELL_COUNT; i++) begin
            wreck[i] = (bus.cells[i] == sub_board_pkg::CELL_WRECK);
            ship[i]  = (bus.cells[i] == sub_board_pkg::CELL_SHIP);
        end
    end

    assign grow = near & wreck & ~reached;   // new wreck cells of this submarine

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            running    <= 1'b0;
            reached    <= '0;
            trace_done <= 1'b0;
            alive      <= 1'b0;
        end else if (trace_start) begin
            running    <= 1'b1;
            reached    <= sub_board_pkg::cell_mask_t'(1) <<
                          sub_board_pkg::cell_index(origin_x, origin_y);
            trace_done <= 1'b0;
            alive      <= 1'b0;
        end else if (running) begin
            if (|(near & ship)) begin          // a live cell touches the wreck chain
                running    <= 1'b0;
                trace_done <= 1'b1;
                alive      <= 1'b1;
            end else if (grow == '0) begin     // chain exhausted with nothing live left
                running    <= 1'b0;
                trace_done <= 1'b1;
                alive      <= 1'b0;
            end else begin
                reached    <= reached | grow;
            end
        end else begin
            trace_done <= 1'b0;
        end
    end

endmodule

// File: source/board_store.sv
/*
  Register array holding the whole board.
  A map load wins over a cell write in the same cycle.
  Writes assume in-range coordinates; the shot controller checks them.
*/
`timescale 1ns/1ps

module board_store (
    input  logic                    clk,
    input  logic                    rstn,
    input  sub_maps_pkg::map_sel_t  init_select,
    input  logic                    select_valid,
    board_if.store                  bus
);

    sub_board_pkg::cell_idx_t wr_idx;

    assign wr_idx = sub_board_pkg::cell_index(bus.wr_x, bus.wr_y);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bus.cells <= '{default: sub_board_pkg::CELL_WATER};   // empty sea
        end else if (select_valid) begin
            bus.cells <= sub_maps_pkg::MAP_TABLE[init_select];
        end else if (bus.wr_en) begin
            bus.cells[wr_idx] <= bus.wr_cell;
        end
    end

endmodule

// File: source/board_if.sv
/*
  Board image plus a single-cell write port.
  A write lands at the edge where wr_en is high and shows on cells
  from the next cycle on.
*/
`timescale 1ns/1ps

interface board_if;

    sub_board_pkg::board_t cells;       // current board image
    logic                  wr_en;
    sub_board_pkg::coord_t wr_x;
    sub_board_pkg::coord_t wr_y;
    sub_board_pkg::cell_t  wr_cell;     // new state of the written cell

    modport store  (output cells, input wr_en, input wr_x, input wr_y, input wr_cell);
    modport writer (input cells, output wr_en, output wr_x, output wr_y, output wr_cell);
    modport reader (input cells);

endinterface

// File: source/sub_maps_pkg.sv
/*
  The four preset maps and their live-cell counts.
  Submarines are straight, 1 to 4 cells long, and never touch each other,
  not even at a corner. The sink check relies on that spacing.
*/
package sub_maps_pkg;

    localparam int MAP_COUNT = 4;

    typedef logic [$clog2(MAP_COUNT)-1:0] map_sel_t;
    typedef logic [5:0] live_count_t;

    // ship cells per map as one 6-bit group per x (x5 first) with y5 at the left of a group
    //
    //   map 0        map 1        map 2        map 3
    //   x0 SSS...    x0 .S...S    x0 SSSS..    x0 S.S.S.
    //   x1 ....S.    x1 .....S    x1 .....S    x1 ......
    //   x2 S...S.    x2 S....S    x2 S....S    x2 SS.S.S
    //   x3 ......    x3 S.S...    x3 S.S...    x3 ......
    //   x4 .SSSS.    x4 ..S...    x4 S...S.    x4 S.SSS.
    //   x5 ......    x5 ..S.SS    x5 ....S.    x5 ......
    localparam sub_board_pkg::cell_mask_t [MAP_COUNT-1:0] SHIP_MASK = {
        36'b000000_011101_000000_101011_000000_010101,   // map 3
        36'b010000_010001_000101_100001_100000_001111,   // map 2
        36'b110100_000100_000101_100001_100000_100010,   // map 1
        36'b000000_011110_000000_010001_010000_000111    // map 0
    };

    // turns a ship mask into a board of water and ship cells
    function automatic sub_board_pkg::board_t expand_map(sub_board_pkg::cell_mask_t ships);
        sub_board_pkg::board_t b;
        for (int i = 0; i < sub_board_pkg::CELL_COUNT; i++) begin
            b[i] = ships[i] ? sub_board_pkg::CELL_SHIP : sub_board_pkg::CELL_WATER;
        end
        return b;
    endfunction

    localparam sub_board_pkg::board_t [MAP_COUNT-1:0] MAP_TABLE = {
        expand_map(SHIP_MASK[3]),
        expand_map(SHIP_MASK[2]),
        expand_map(SHIP_MASK[1]),
        expand_map(SHIP_MASK[0])
    };

    // live cells at load time, derived from the same masks as the boards
    localparam live_count_t [MAP_COUNT-1:0] MAP_LIVE = {
        live_count_t'($countones(SHIP_MASK[3])),
        live_count_t'($countones(SHIP_MASK[2])),
        live_count_t'($countones(SHIP_MASK[1])),
        live_count_t'($countones(SHIP_MASK[0]))
    };

endpackage

// File: source/sub_board_pkg.sv
/*
  Board geometry and cell encoding for the 6 by 6 submarine grid.
  A cell sits at index x*6+y. Coordinates are 3 bits wide, so 6 and 7 can
  reach the design and must be range checked by whoever accepts them.
*/
package sub_board_pkg;

    localparam int BOARD_DIM  = 6;
    localparam int CELL_COUNT = BOARD_DIM * BOARD_DIM;

    typedef logic [2:0] coord_t;                          // one grid coordinate
    typedef logic [$clog2(CELL_COUNT)-1:0] cell_idx_t;    // flat cell index

    // a wreck is a ship cell that has already been struck
    typedef enum logic [1:0] {
        CELL_WATER = 2'd0,
        CELL_SHIP  = 2'd1,
        CELL_WRECK = 2'd2
    } cell_t;

    typedef cell_t [CELL_COUNT-1:0] board_t;         // whole board with cell 0 in the low bits
    typedef logic [CELL_COUNT-1:0]  cell_mask_t;     // one flag per cell

    // flat index of an in-range coordinate pair
    function automatic cell_idx_t cell_index(coord_t x, coord_t y);
        return cell_idx_t'(int'(x) * BOARD_DIM + int'(y));
    endfunction

endpackage
